// File: include/calc_params.svh
// Calculator parameters
// Data and register widths, stage depth and the fixed pipe latencies

`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// Datapath widths
`define CALC_XLEN 64
`define CALC_REG_AW 5

// Stage-info entries behind the reservation register
`define CALC_STAGES 4

// Stage whose pipe result is muxed into the completion pipe
`define CALC_INT_DONE 0
`define CALC_MUL_DONE 1

`define CALC_COMMIT_STAGE 2
`define CALC_WB_STAGE 3

`endif

// File: rtl/calc_pkg.sv
// Calculator package
// Operation encoding, the dispatch packet and the per-stage control record

`include "calc_params.svh"

package calc_pkg;

  typedef enum logic [3:0]
  {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_sll = 4'd5,
    op_srl = 4'd6,
    op_slt = 4'd7,
    op_mul = 4'd8
  } calc_op_e;

  // Packet as it leaves dispatch and sits in the reservation register
  typedef struct packed
  {
    logic                    v;
    logic                    poison;
    calc_op_e                op;
    logic [`CALC_REG_AW-1:0] rs1_addr;
    logic [`CALC_REG_AW-1:0] rs2_addr;
    logic [`CALC_XLEN-1:0]   rs1;
    logic [`CALC_XLEN-1:0]   rs2;
    logic [`CALC_REG_AW-1:0] rd_addr;
    logic                    rd_w_v;
    logic [31:0]             pc;
  } dispatch_pkt_s;

  // What each stage keeps once the operands are consumed
  typedef struct packed
  {
    logic                    v;
    logic [31:0]             pc;
    logic [`CALC_REG_AW-1:0] rd_addr;
    logic                    rd_w_v;
    logic                    int_v;
    logic                    mul_v;
  } stage_info_s;

endpackage

// File: rtl/calc_stage_if.sv
// Stage bundle
// Per-stage control, poison and next-cycle completion data shared by
// the stage control, the completion pipe and the bypass network

`timescale 1ns/1ps

`include "calc_params.svh"

interface calc_stage_if;

  calc_pkg::stage_info_s [`CALC_STAGES-1:0]         info;
  logic [`CALC_STAGES-1:0]                          poison_nxt;
  logic [`CALC_STAGES-1:0][`CALC_XLEN-1:0]          fwd_data;

  // Stage control owns the shift pipe
  modport ctrl_mp (output info, output poison_nxt);

  // Completion pipe follows the stage pipe and publishes its next values
  modport comp_mp (input info, input poison_nxt, output fwd_data);

  modport bypass_mp (input info, input poison_nxt, input fwd_data);

endinterface

// File: rtl/calc_bypass.sv
// Operand bypass
// Replaces each dispatched source operand with the youngest in-flight
// result headed for the same register

`timescale 1ns/1ps

`include "calc_params.svh"

module calc_bypass
  (input  calc_pkg::dispatch_pkt_s  dispatch_i
  , calc_stage_if.bypass_mp         stage
  , output logic [`CALC_XLEN-1:0]   rs1_o
  , output logic [`CALC_XLEN-1:0]   rs2_o
  );

  logic [`CALC_STAGES-1:0] fwd_v;
  logic [`CALC_STAGES-1:0] rs1_hit;
  logic [`CALC_STAGES-1:0] rs2_hit;

  // rd_w_v already implies a valid stage
  always_comb
  begin
    for (int i = 0; i < `CALC_STAGES; i++)
    begin
      fwd_v[i]   = stage.info[i].rd_w_v & ~stage.poison_nxt[i];
      rs1_hit[i] = fwd_v[i] & (stage.info[i].rd_addr == dispatch_i.rs1_addr);
      rs2_hit[i] = fwd_v[i] & (stage.info[i].rd_addr == dispatch_i.rs2_addr);
    end
  end

  // Walk from the oldest stage so the youngest hit wins
  always_comb
  begin
    rs1_o = dispatch_i.rs1;
    rs2_o = dispatch_i.rs2;
    for (int i = `CALC_STAGES-1; i >= 0; i--)
    begin
      if (rs1_hit[i])
      begin
        rs1_o = stage.fwd_data[i];
      end
      if (rs2_hit[i])
      begin
        rs2_o = stage.fwd_data[i];
      end
    end
  end

  // Stage control strips writes to x0 before they enter the pipe
  always_comb
  begin
    for (int i = 0; i < `CALC_STAGES; i++)
    begin
      assert (!(rs1_hit[i] || rs2_hit[i]) || (stage.info[i].rd_addr != '0))
        else $error("calc_bypass: x0 forwarded from stage %0d", i);
    end
  end

endmodule

// File: rtl/calc_pipe_int.sv
// Integer ALU pipe
// Single-cycle add, sub, logic, shift and signed compare over the
// reservation register

`timescale 1ns/1ps

`include "calc_params.svh"

module calc_pipe_int
  (input  calc_pkg::dispatch_pkt_s  issue_i
  , output logic [`CALC_XLEN-1:0]   data_o
  );

  localparam int shamt_width_lp = $clog2(`CALC_XLEN);

  logic [`CALC_XLEN-1:0]     rs1;
  logic [`CALC_XLEN-1:0]     rs2;
  logic [shamt_width_lp-1:0] shamt;

  assign rs1   = issue_i.rs1;
  assign rs2   = issue_i.rs2;
  assign shamt = rs2[shamt_width_lp-1:0];

  always_comb
  begin
    case (issue_i.op)
      calc_pkg::op_add: data_o = rs1 + rs2;
      calc_pkg::op_sub: data_o = rs1 - rs2;
      calc_pkg::op_and: data_o = rs1 & rs2;
      calc_pkg::op_or:  data_o = rs1 | rs2;
      calc_pkg::op_xor: data_o = rs1 ^ rs2;
      calc_pkg::op_sll: data_o = rs1 << shamt;
      calc_pkg::op_srl: data_o = rs1 >> shamt;
      calc_pkg::op_slt: data_o = `CALC_XLEN'($signed(rs1) < $signed(rs2));
      // op_mul belongs to the multiply pipe
      default:          data_o = '0;
    endcase
  end

endmodule

// File: rtl/calc_pipe_mul.sv
// Multiply pipe
// Registers the low XLEN bits of rs1 * rs2 so the product is ready one
// cycle after the issue cycle

`timescale 1ns/1ps

`include "calc_params.svh"

module calc_pipe_mul
  (input                            clk_i
  , input                           rst_n_i
  , input  calc_pkg::dispatch_pkt_s issue_i
  , output logic [`CALC_XLEN-1:0]   data_o
  );

  logic                  is_mul;
  logic                  mul_v_r;
  logic [`CALC_XLEN-1:0] prod_r;

  assign is_mul = issue_i.v & (issue_i.op == calc_pkg::op_mul);

  // Product only loads on a multiply
  always_ff @(posedge clk_i)
  begin
    if (is_mul)
    begin
      prod_r <= issue_i.rs1 * issue_i.rs2;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mul_v_r <= 1'b0;
    end
    else
    begin
      mul_v_r <= is_mul;
    end
  end

  assign data_o = mul_v_r ? prod_r : '0;

endmodule

// File: rtl/calc_stage_ctrl.sv
// Stage control
// Reservation register, stage-info shift pipe with poison and flush,
// commit report and per-stage pending-write status

`timescale 1ns/1ps

`include "calc_params.svh"

module calc_stage_ctrl
  (input                                    clk_i
  , input                                   rst_n_i
  , input  calc_pkg::dispatch_pkt_s         dispatch_i
  , input  logic [`CALC_XLEN-1:0]           rs1_i
  , input  logic [`CALC_XLEN-1:0]           rs2_i
  , input                                   flush_i
  , calc_stage_if.ctrl_mp                   stage
  , output calc_pkg::dispatch_pkt_s         issue_o
  , output logic                            commit_v_o
  , output logic [31:0]                     commit_pc_o
  , output logic [`CALC_STAGES-1:0]         pending_w_o
  );

  calc_pkg::dispatch_pkt_s                  reservation_n;
  calc_pkg::dispatch_pkt_s                  reservation_r;
  calc_pkg::stage_info_s                    isd_info;
  calc_pkg::stage_info_s [`CALC_STAGES-1:0] info_r;
  logic [`CALC_STAGES-1:0]                  poison_r;
  logic [`CALC_STAGES-1:0]                  poison_n;

  // Bypassed operands override the dispatched ones
  always_comb
  begin
    reservation_n     = dispatch_i;
    reservation_n.rs1 = rs1_i;
    reservation_n.rs2 = rs2_i;
  end

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
  end

  assign issue_o = reservation_r;

  // A write to x0 is dropped here and never reaches bypass or writeback
  // ALU ops occupy the encodings up to op_slt
  always_comb
  begin
    isd_info.v       = dispatch_i.v;
    isd_info.pc      = dispatch_i.pc;
    isd_info.rd_addr = dispatch_i.rd_addr;
    isd_info.rd_w_v  = dispatch_i.v & dispatch_i.rd_w_v & (dispatch_i.rd_addr != '0);
    isd_info.int_v   = dispatch_i.v & (dispatch_i.op <= calc_pkg::op_slt);
    isd_info.mul_v   = dispatch_i.v & (dispatch_i.op == calc_pkg::op_mul);
  end

  // Flush only reaches stages ahead of the commit point
  always_comb
  begin
    for (int i = 0; i < `CALC_STAGES; i++)
    begin
      poison_n[i]    = poison_r[i] | (flush_i & (i < `CALC_COMMIT_STAGE));
      pending_w_o[i] = info_r[i].rd_w_v & ~poison_n[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      info_r     <= '0;
      poison_r   <= '0;
      commit_v_o <= 1'b0;
    end
    else
    begin
      info_r     <= {info_r[`CALC_STAGES-2:0], isd_info};
      poison_r   <= {poison_n[`CALC_STAGES-2:0], dispatch_i.poison | flush_i};
      commit_v_o <= info_r[`CALC_COMMIT_STAGE].v & ~poison_n[`CALC_COMMIT_STAGE];
    end
  end

  always_ff @(posedge clk_i)
  begin
    commit_pc_o <= info_r[`CALC_COMMIT_STAGE].pc;
  end

  assign stage.info       = info_r;
  assign stage.poison_nxt = poison_n;

  // The completion mux relies on exactly one pipe per valid instruction
  for (genvar g = 0; g < `CALC_STAGES; g++)
  begin : g_one_pipe
    a_one_pipe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      info_r[g].v |-> (info_r[g].int_v ^ info_r[g].mul_v))
      else $error("calc_stage_ctrl: stage %0d does not claim exactly one pipe", g);
  end

endmodule

// File: rtl/calc_completion.sv
// Completion pipe
// Muxes each pipe result in at its fixed latency, carries it down to
// writeback and publishes the next-cycle values for forwarding

`timescale 1ns/1ps

`include "calc_params.svh"

module calc_completion
  (input                              clk_i
  , input                             rst_n_i
  , input  logic [`CALC_XLEN-1:0]     int_data_i
  , input  logic [`CALC_XLEN-1:0]     mul_data_i
  , calc_stage_if.comp_mp             stage
  , output logic                      wb_v_o
  , output logic [`CALC_REG_AW-1:0]   wb_addr_o
  , output logic [`CALC_XLEN-1:0]     wb_data_o
  );

  logic [`CALC_STAGES-1:0][`CALC_XLEN-1:0] comp_r;
  logic [`CALC_STAGES-1:0][`CALC_XLEN-1:0] comp_n;

  // Single issue with static latencies means at most one pipe lands per stage
  always_comb
  begin
    comp_n[0] = '0;
    for (int i = 1; i < `CALC_STAGES; i++)
    begin
      comp_n[i] = comp_r[i-1];
    end
    if (stage.info[`CALC_INT_DONE].int_v)
    begin
      comp_n[`CALC_INT_DONE] = int_data_i;
    end
    if (stage.info[`CALC_MUL_DONE].mul_v)
    begin
      comp_n[`CALC_MUL_DONE] = mul_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    comp_r <= comp_n;
  end

  // A mul still in stage 0 forwards the empty value
  assign stage.fwd_data = comp_n;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wb_v_o <= 1'b0;
    end
    else
    begin
      wb_v_o <= stage.info[`CALC_WB_STAGE].rd_w_v & ~stage.poison_nxt[`CALC_WB_STAGE];
    end
  end

  always_ff @(posedge clk_i)
  begin
    wb_addr_o <= stage.info[`CALC_WB_STAGE].rd_addr;
  end

  assign wb_data_o = comp_r[`CALC_WB_STAGE];

  a_wb_no_x0 : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_v_o |-> (wb_addr_o != '0))
    else $error("calc_completion: writeback to x0");

endmodule

// File: rtl/calc_top.sv
// Integer calculator
// Bypass, reservation register, ALU and multiply pipes, completion pipe,
// commit report and register writeback

`timescale 1ns/1ps

`include "calc_params.svh"

module calc_top
  (input  logic                       clk_i
  , input  logic                      rst_n_i
  , input  logic                      dispatch_v_i
  , input  logic                      dispatch_poison_i
  , input  logic [3:0]                dispatch_op_i
  , input  logic [`CALC_REG_AW-1:0]   rs1_addr_i
  , input  logic [`CALC_REG_AW-1:0]   rs2_addr_i
  , input  logic [`CALC_XLEN-1:0]     rs1_data_i
  , input  logic [`CALC_XLEN-1:0]     rs2_data_i
  , input  logic [`CALC_REG_AW-1:0]   rd_addr_i
  , input  logic                      rd_w_v_i
  , input  logic [31:0]               pc_i
  , input  logic                      flush_i
  , output logic                      commit_v_o
  , output logic [31:0]               commit_pc_o
  , output logic                      wb_v_o
  , output logic [`CALC_REG_AW-1:0]   wb_addr_o
  , output logic [`CALC_XLEN-1:0]     wb_data_o
  , output logic [`CALC_STAGES-1:0]   pending_w_o
  );

  calc_pkg::dispatch_pkt_s dispatch_pkt;
  calc_pkg::dispatch_pkt_s issue_pkt;
  logic [`CALC_XLEN-1:0]   bypass_rs1;
  logic [`CALC_XLEN-1:0]   bypass_rs2;
  logic [`CALC_XLEN-1:0]   int_data;
  logic [`CALC_XLEN-1:0]   mul_data;

  assign dispatch_pkt = '{
    v:        dispatch_v_i,
    poison:   dispatch_poison_i,
    op:       calc_pkg::calc_op_e'(dispatch_op_i),
    rs1_addr: rs1_addr_i,
    rs2_addr: rs2_addr_i,
    rs1:      rs1_data_i,
    rs2:      rs2_data_i,
    rd_addr:  rd_addr_i,
    rd_w_v:   rd_w_v_i,
    pc:       pc_i
  };

  calc_stage_if stage_if ();

  calc_bypass bypass
    (.dispatch_i(dispatch_pkt)
    , .stage(stage_if.bypass_mp)
    , .rs1_o(bypass_rs1)
    , .rs2_o(bypass_rs2)
    );

  calc_stage_ctrl stage_ctrl
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .dispatch_i(dispatch_pkt)
    , .rs1_i(bypass_rs1)
    , .rs2_i(bypass_rs2)
    , .flush_i(flush_i)
    , .stage(stage_if.ctrl_mp)
    , .issue_o(issue_pkt)
    , .commit_v_o(commit_v_o)
    , .commit_pc_o(commit_pc_o)
    , .pending_w_o(pending_w_o)
    );

  calc_pipe_int pipe_int
    (.issue_i(issue_pkt)
    , .data_o(int_data)
    );

  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .issue_i(issue_pkt)
    , .data_o(mul_data)
    );

  calc_completion completion
    (.clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .int_data_i(int_data)
    , .mul_data_i(mul_data)
    , .stage(stage_if.comp_mp)
    , .wb_v_o(wb_v_o)
    , .wb_addr_o(wb_addr_o)
    , .wb_data_o(wb_data_o)
    );

endmodule

// File: sim/calc_tb.sv
// Integer calculator testbench
// Applies a table of dispatches, keeps a writeback-fed register file for
// operands and a dispatch-order model for expected commit and writeback

`timescale 1ns/1ps

`include "calc_params.svh"

module calc_tb;

  localparam int clk_period      = 8;
  localparam int drive_delay     = 1;
  localparam int reset_cycles    = 4;
  localparam int num_rows        = 41;
  localparam int drain_cycles    = 6;
  localparam int watchdog_cycles = num_rows + 20;
  localparam logic [31:0] seed_value = 32'h07d1_e105;

  typedef struct packed
  {
    logic                    v;
    logic [3:0]              op;
    logic [`CALC_REG_AW-1:0] rs1;
    logic [`CALC_REG_AW-1:0] rs2;
    logic [`CALC_REG_AW-1:0] rd;
    logic                    poison;
    logic                    flush;
    logic [31:0]             pc;
  } row_t;

  typedef struct packed
  {
    int          due;
    logic [31:0] pc;
  } commit_ev_t;

  typedef struct packed
  {
    int                      due;
    logic [`CALC_REG_AW-1:0] addr;
    logic [`CALC_XLEN-1:0]   data;
  } wb_ev_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    dispatch_v;
  logic                    dispatch_poison;
  logic [3:0]              dispatch_op;
  logic [`CALC_REG_AW-1:0] rs1_addr;
  logic [`CALC_REG_AW-1:0] rs2_addr;
  logic [`CALC_XLEN-1:0]   rs1_data;
  logic [`CALC_XLEN-1:0]   rs2_data;
  logic [`CALC_REG_AW-1:0] rd_addr;
  logic                    rd_w_v;
  logic [31:0]             pc;
  logic                    flush;
  logic                    commit_v;
  logic [31:0]             commit_pc;
  logic                    wb_v;
  logic [`CALC_REG_AW-1:0] wb_addr;
  logic [`CALC_XLEN-1:0]   wb_data;
  logic [`CALC_STAGES-1:0] pending_w;

  row_t                  stim [num_rows];
  int                    n_rows;
  // Operand source, written only by DUT writeback
  logic [`CALC_XLEN-1:0] rf_wb [2**`CALC_REG_AW];
  // Architectural state, applied in dispatch order
  logic [`CALC_XLEN-1:0] rf_arch [2**`CALC_REG_AW];
  commit_ev_t            commit_q [$];
  wb_ev_t                wb_q [$];
  int                    checks;
  int                    errors;

  always #(clk_period/2) clk = ~clk;

  calc_top dut
    (.clk_i(clk)
    , .rst_n_i(rst_n)
    , .dispatch_v_i(dispatch_v)
    , .dispatch_poison_i(dispatch_poison)
    , .dispatch_op_i(dispatch_op)
    , .rs1_addr_i(rs1_addr)
    , .rs2_addr_i(rs2_addr)
    , .rs1_data_i(rs1_data)
    , .rs2_data_i(rs2_data)
    , .rd_addr_i(rd_addr)
    , .rd_w_v_i(rd_w_v)
    , .pc_i(pc)
    , .flush_i(flush)
    , .commit_v_o(commit_v)
    , .commit_pc_o(commit_pc)
    , .wb_v_o(wb_v)
    , .wb_addr_o(wb_addr)
    , .wb_data_o(wb_data)
    , .pending_w_o(pending_w)
    );

  task automatic add_row(input logic v, input logic [3:0] op, input int rs1, input int rs2,
                         input int rd, input logic poison, input logic flush_v,
                         input logic [31:0] row_pc);
    row_t row;
    row.v      = v;
    row.op     = op;
    row.rs1    = rs1[`CALC_REG_AW-1:0];
    row.rs2    = rs2[`CALC_REG_AW-1:0];
    row.rd     = rd[`CALC_REG_AW-1:0];
    row.poison = poison;
    row.flush  = flush_v;
    row.pc     = row_pc;
    stim[n_rows] = row;
    n_rows++;
  endtask

  // Columns: valid, op, rs1, rs2, rd, poison, flush, pc
  task automatic build_table();
    add_row(1, calc_pkg::op_add, 2, 3, 1, 0, 0, 32'h100);
    add_row(1, calc_pkg::op_sub, 1, 5, 4, 0, 0, 32'h104);
    add_row(1, calc_pkg::op_and, 4, 1, 6, 0, 0, 32'h108);
    add_row(1, calc_pkg::op_or,  6, 4, 7, 0, 0, 32'h10c);
    add_row(1, calc_pkg::op_xor, 7, 6, 8, 0, 0, 32'h110);
    add_row(1, calc_pkg::op_sll, 8, 3, 9, 0, 0, 32'h114);
    add_row(1, calc_pkg::op_srl, 9, 2, 10, 0, 0, 32'h118);
    add_row(1, calc_pkg::op_slt, 10, 1, 11, 0, 0, 32'h11c);
    add_row(1, calc_pkg::op_mul, 2, 3, 12, 0, 0, 32'h120);
    add_row(1, calc_pkg::op_add, 4, 5, 13, 0, 0, 32'h124);
    add_row(1, calc_pkg::op_mul, 12, 13, 14, 0, 0, 32'h128);
    add_row(0, calc_pkg::op_add, 0, 0, 0, 0, 0, 32'h12c);
    add_row(1, calc_pkg::op_add, 14, 1, 15, 0, 0, 32'h130);
    // x0 destination followed by x0 readers
    add_row(1, calc_pkg::op_add, 2, 3, 0, 0, 0, 32'h134);
    add_row(1, calc_pkg::op_or,  0, 5, 16, 0, 0, 32'h138);
    add_row(1, calc_pkg::op_xor, 0, 15, 17, 0, 0, 32'h13c);
    add_row(1, calc_pkg::op_add, 17, 16, 18, 0, 0, 32'h140);
    // Flush on row 19 kills rows 17 to 19, row 16 completes
    add_row(1, calc_pkg::op_add, 18, 2, 19, 0, 0, 32'h144);
    add_row(1, calc_pkg::op_sub, 19, 3, 20, 0, 0, 32'h148);
    add_row(1, calc_pkg::op_add, 2, 20, 21, 0, 1, 32'h14c);
    add_row(1, calc_pkg::op_add, 19, 20, 22, 0, 0, 32'h150);
    add_row(0, calc_pkg::op_add, 0, 0, 0, 0, 0, 32'h154);
    add_row(1, calc_pkg::op_add, 18, 1, 23, 1, 0, 32'h158);
    add_row(1, calc_pkg::op_add, 23, 18, 24, 0, 0, 32'h15c);
    add_row(0, calc_pkg::op_add, 0, 0, 0, 0, 0, 32'h160);
    add_row(1, calc_pkg::op_mul, 24, 16, 25, 0, 0, 32'h164);
    add_row(0, calc_pkg::op_add, 0, 0, 0, 0, 1, 32'h168);
    add_row(1, calc_pkg::op_add, 25, 24, 26, 0, 0, 32'h16c);
    add_row(1, calc_pkg::op_mul, 26, 26, 27, 0, 0, 32'h170);
    add_row(1, calc_pkg::op_slt, 3, 2, 28, 0, 0, 32'h174);
    add_row(1, calc_pkg::op_add, 27, 28, 29, 0, 0, 32'h178);
    add_row(1, calc_pkg::op_sll, 29, 28, 30, 0, 0, 32'h17c);
    add_row(1, calc_pkg::op_srl, 30, 9, 31, 0, 0, 32'h180);
    add_row(1, calc_pkg::op_add, 31, 30, 1, 0, 0, 32'h184);
    add_row(1, calc_pkg::op_sub, 1, 31, 1, 0, 0, 32'h188);
    add_row(1, calc_pkg::op_add, 1, 1, 2, 0, 0, 32'h18c);
    add_row(1, calc_pkg::op_xor, 31, 30, 3, 0, 0, 32'h190);
    add_row(1, calc_pkg::op_or,  1, 2, 5, 0, 0, 32'h194);
    add_row(1, calc_pkg::op_mul, 3, 5, 6, 0, 0, 32'h198);
    add_row(0, calc_pkg::op_add, 0, 0, 0, 0, 0, 32'h19c);
    add_row(1, calc_pkg::op_add, 6, 6, 7, 0, 0, 32'h1a0);
  endtask

  function automatic logic [`CALC_XLEN-1:0] expected_result(input logic [3:0] op,
                                                           input logic [`CALC_XLEN-1:0] a,
                                                           input logic [`CALC_XLEN-1:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (op)
      calc_pkg::op_add: return a + b;
      calc_pkg::op_sub: return a - b;
      calc_pkg::op_and: return a & b;
      calc_pkg::op_or:  return a | b;
      calc_pkg::op_xor: return a ^ b;
      calc_pkg::op_sll: return a << sh;
      calc_pkg::op_srl: return a >> sh;
      calc_pkg::op_slt: return {{(`CALC_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      calc_pkg::op_mul: return a * b;
      default:          return '0;
    endcase
  endfunction

  // Poisoned at dispatch, or hit by a flush from rows r to r+2 seen so far
  function automatic logic is_dead(input int r, input int last_row);
    logic dead;
    int   stop;
    dead = stim[r].poison;
    stop = (last_row < r + 2) ? last_row : r + 2;
    if (stop > num_rows - 1)
    begin
      stop = num_rows - 1;
    end
    for (int i = r; i <= stop; i++)
    begin
      dead = dead | stim[i].flush;
    end
    return dead;
  endfunction

  // Stage s holds the row dispatched s+1 edges ago
  function automatic logic [`CALC_STAGES-1:0] expected_pending(input int iter);
    logic [`CALC_STAGES-1:0] bits;
    int                      r;
    bits = '0;
    for (int s = 0; s < `CALC_STAGES; s++)
    begin
      r = iter - 1 - s;
      if (r >= 0 && r < num_rows)
      begin
        bits[s] = stim[r].v && (stim[r].rd != '0) && !is_dead(r, iter - 1);
      end
    end
    return bits;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    checks++;
    assert (got == want)
    else
    begin
      errors++;
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_outputs(input int iter);
    commit_ev_t cev;
    wb_ev_t     wev;
    if (commit_q.size() > 0 && commit_q[0].due == iter)
    begin
      cev = commit_q.pop_front();
      check_value("commit_v_o", 64'(commit_v), 64'd1);
      check_value("commit_pc_o", 64'(commit_pc), 64'(cev.pc));
    end
    else
    begin
      check_value("commit_v_o", 64'(commit_v), 64'd0);
    end
    if (wb_q.size() > 0 && wb_q[0].due == iter)
    begin
      wev = wb_q.pop_front();
      check_value("wb_v_o", 64'(wb_v), 64'd1);
      check_value("wb_addr_o", 64'(wb_addr), 64'(wev.addr));
      check_value("wb_data_o", wb_data, wev.data);
    end
    else
    begin
      check_value("wb_v_o", 64'(wb_v), 64'd0);
    end
    if (wb_v === 1'b1 && wb_addr != '0)
    begin
      rf_wb[wb_addr] = wb_data;
    end
    check_value("pending_w_o", 64'(pending_w), 64'(expected_pending(iter)));
  endtask

  task automatic drive_idle();
    dispatch_v      = 1'b0;
    dispatch_poison = 1'b0;
    dispatch_op     = '0;
    rs1_addr        = '0;
    rs2_addr        = '0;
    rs1_data        = '0;
    rs2_data        = '0;
    rd_addr         = '0;
    rd_w_v          = 1'b0;
    pc              = '0;
    flush           = 1'b0;
  endtask

  // Row k is sampled at edge k+1, commits at k+4 and writes back at k+5
  task automatic dispatch_row(input int k);
    row_t                  row;
    logic [`CALC_XLEN-1:0] res;
    row             = stim[k];
    dispatch_v      = row.v;
    dispatch_poison = row.poison;
    dispatch_op     = row.op;
    rs1_addr        = row.rs1;
    rs2_addr        = row.rs2;
    rs1_data        = rf_wb[row.rs1];
    rs2_data        = rf_wb[row.rs2];
    rd_addr         = row.rd;
    rd_w_v          = row.v;
    pc              = row.pc;
    flush           = row.flush;
    if (row.v && !is_dead(k, k + 2))
    begin
      res = expected_result(row.op, rf_arch[row.rs1], rf_arch[row.rs2]);
      commit_q.push_back('{due: k + 4, pc: row.pc});
      if (row.rd != '0)
      begin
        rf_arch[row.rd] = res;
        wb_q.push_back('{due: k + 5, addr: row.rd, data: res});
      end
    end
  endtask

  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles before the test ended", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    logic [`CALC_XLEN-1:0] seed_val;
    drive_idle();
    rst_n  = 1'b0;
    checks = 0;
    errors = 0;
    n_rows = 0;
    void'($urandom(seed_value));
    rf_wb[0]   = '0;
    rf_arch[0] = '0;
    for (int i = 1; i < 2**`CALC_REG_AW; i++)
    begin
      seed_val   = {$urandom, $urandom};
      rf_wb[i]   = seed_val;
      rf_arch[i] = seed_val;
    end
    build_table();
    if (n_rows != num_rows)
    begin
      errors++;
      $display("Stimulus table holds %0d rows instead of %0d", n_rows, num_rows);
    end
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;
    for (int k = 0; k < num_rows + drain_cycles; k++)
    begin
      @(posedge clk);
      #(drive_delay);
      check_outputs(k);
      if (k < num_rows)
      begin
        dispatch_row(k);
      end
      else
      begin
        drive_idle();
      end
    end
    if (commit_q.size() != 0 || wb_q.size() != 0)
    begin
      errors++;
      $display("Expected events never arrived: %0d commits, %0d writebacks",
               commit_q.size(), wb_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
rtl/calc_pkg.sv
rtl/calc_stage_if.sv
rtl/calc_bypass.sv
rtl/calc_pipe_int.sv
rtl/calc_pipe_mul.sv
rtl/calc_stage_ctrl.sv
rtl/calc_completion.sv
rtl/calc_top.sv
sim/calc_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= calc_tb
LINT_TOP   ?= calc_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard rtl/*.sv sim/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
